// ==== verilog/pcie_bridge_settings.svh ====
`ifndef PCIE_BRIDGE_SETTINGS_SVH
`define PCIE_BRIDGE_SETTINGS_SVH

// --------------------------------------------------
// stream widths
// --------------------------------------------------

// core side, one beat of the 64-bit core interface
`define CORE_DATA_W 64
// user side, one 128-bit word
`define TLPS_DATA_W 128
`define TLPS_DWORDS 4
// bar hit tag carried alongside each receive beat
`define BAR_HIT_W 7

// --------------------------------------------------
// legacy interrupt timer
// --------------------------------------------------

// cycles of clk_pcie between two requests
`define INT_PERIOD_DEFAULT 100000
`define INT_COUNT_W 32

`endif

// ==== verilog/tlp_stream_pkg.sv ====
`include "pcie_bridge_settings.svh"

package tlp_stream_pkg;

    // --------------------------------------------------
    // core side
    // --------------------------------------------------

    // one beat, two dwords
    typedef logic [`CORE_DATA_W-1:0] core_beat_t;
    // byte keep, 0x0f or 0xff in practice
    typedef logic [`CORE_DATA_W/8-1:0] core_keep_t;

    // --------------------------------------------------
    // user side
    // --------------------------------------------------

    // one word, four dwords
    typedef logic [`TLPS_DATA_W-1:0] tlps_word_t;
    // one bit per valid dword, low bits first
    typedef logic [`TLPS_DWORDS-1:0] keepdw_t;
    typedef logic [`BAR_HIT_W-1:0] bar_hit_t;

    // dwords gathered in the word under construction
    // wide enough for a full word plus a two-dword beat
    typedef logic [3:0] dword_count_t;

endpackage

// ==== verilog/pcie_cfg_pkg.sv ====
`include "pcie_bridge_settings.svh"

package pcie_cfg_pkg;

    // --------------------------------------------------
    // interrupt timer
    // --------------------------------------------------

    // free-running tick count between two legacy
    // interrupt requests, wraps at the configured period
    typedef logic [`INT_COUNT_W-1:0] int_count_t;

endpackage

// ==== verilog/tlp_rx_packer.sv ====
`timescale 1ns/1ps
`include "pcie_bridge_settings.svh"

module tlp_rx_packer (
    input  logic                      clk_pcie,
    input  logic                      rst,

    // core receive beats, always accepted
    input  tlp_stream_pkg::core_beat_t rx_data,
    input  logic                      rx_two_dw,
    input  logic                      rx_last,
    input  tlp_stream_pkg::bar_hit_t  rx_bar_hit,
    input  logic                      rx_valid,

    // packed user words, no back-pressure
    output tlp_stream_pkg::tlps_word_t rxs_data,
    output tlp_stream_pkg::keepdw_t   rxs_keepdw,
    output logic                      rxs_first,
    output logic                      rxs_last,
    output tlp_stream_pkg::bar_hit_t  rxs_bar_hit,
    output logic                      rxs_valid
);

    import tlp_stream_pkg::*;

    localparam int DW_W = `TLPS_DATA_W / `TLPS_DWORDS;

    dword_count_t dw_count;
    dword_count_t next_base;
    dword_count_t next_count;

    // --------------------------------------------------
    // word status
    // --------------------------------------------------

    // full enough, or the tlp ended
    assign rxs_valid = rxs_last || (dw_count > dword_count_t'(2));

    always_comb begin
        for (int i = 0; i < `TLPS_DWORDS; i++) begin
            rxs_keepdw[i] = (dw_count > dword_count_t'(i));
        end
    end

    // emitted word frees the register for the next one
    assign next_base  = rxs_valid ? dword_count_t'(0) : dw_count;
    assign next_count = next_base + (rx_two_dw ? dword_count_t'(2) : dword_count_t'(1));

    // --------------------------------------------------
    // control state
    // --------------------------------------------------

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            dw_count  <= '0;
            rxs_first <= 1'b1;
            rxs_last  <= 1'b0;
        end else begin
            // the word after a tlp's final word opens the next tlp
            if (rxs_valid) begin
                rxs_first <= rxs_last;
            end

            if (rx_valid) begin
                dw_count <= next_count;
                rxs_last <= rx_last;
            end else if (rxs_valid) begin
                dw_count <= '0;
                rxs_last <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // payload
    // --------------------------------------------------

    // base never exceeds 2, so a two-dword beat always fits
    always_ff @(posedge clk_pcie) begin
        if (rx_valid) begin
            rxs_data[DW_W*next_base +: `CORE_DATA_W] <= rx_data;
            rxs_bar_hit                              <= rx_bar_hit;
        end
    end

endmodule

// ==== verilog/tlp_tx_splitter.sv ====
`timescale 1ns/1ps
`include "pcie_bridge_settings.svh"

module tlp_tx_splitter (
    input  logic                       clk_pcie,
    input  logic                       rst,

    // user words
    input  tlp_stream_pkg::tlps_word_t txs_data,
    input  tlp_stream_pkg::keepdw_t    txs_keepdw,
    input  logic                       txs_last,
    input  logic                       txs_valid,
    output logic                       txs_ready,

    // core transmit beats
    output tlp_stream_pkg::core_beat_t tx_data,
    output tlp_stream_pkg::core_keep_t tx_keep,
    output logic                       tx_last,
    output logic                       tx_valid,
    input  logic                       tx_ready
);

    import tlp_stream_pkg::*;

    // set while the stored high half is on the core side
    logic       hi_phase;
    core_beat_t hi_data;
    logic [1:0] hi_keepdw;
    logic       hi_last;

    logic       two_beat;
    logic [1:0] beat_dw;

    // word needs a second beat for dwords 2 and 3
    assign two_beat = txs_valid && txs_keepdw[2];

    // --------------------------------------------------
    // beat select
    // --------------------------------------------------

    assign tx_valid = hi_phase || txs_valid;
    assign tx_data  = hi_phase ? hi_data : txs_data[`CORE_DATA_W-1:0];
    assign beat_dw  = hi_phase ? hi_keepdw : txs_keepdw[1:0];
    // one keep nibble per dword of the beat
    assign tx_keep  = {{4{beat_dw[1]}}, {4{beat_dw[0]}}};
    assign tx_last  = hi_phase ? hi_last : (txs_last && !txs_keepdw[2]);

    // word is consumed with its final beat only
    assign txs_ready = tx_ready && (hi_phase || !two_beat);

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            hi_phase <= 1'b0;
        end else if (tx_ready) begin
            if (hi_phase) begin
                hi_phase <= 1'b0;
            end else if (two_beat) begin
                hi_phase <= 1'b1;
            end
        end
    end

    // capture the upper half as the lower half goes out
    always_ff @(posedge clk_pcie) begin
        if (tx_ready && !hi_phase && two_beat) begin
            hi_data   <= txs_data[`TLPS_DATA_W-1:`CORE_DATA_W];
            hi_keepdw <= txs_keepdw[3:2];
            hi_last   <= txs_last;
        end
    end

endmodule

// ==== verilog/legacy_int_requester.sv ====
`timescale 1ns/1ps
`include "pcie_bridge_settings.svh"

module legacy_int_requester #(
    parameter int INT_PERIOD = `INT_PERIOD_DEFAULT
) (
    input  logic clk_pcie,
    input  logic rst,

    // request towards the core, held until accepted
    output logic int_valid,
    input  logic int_ready
);

    import pcie_cfg_pkg::*;

    localparam int_count_t WRAP_AT = int_count_t'(INT_PERIOD - 1);

    int_count_t tick;
    logic       wrap;

    // --------------------------------------------------
    // period timer
    // --------------------------------------------------

    // one pulse every INT_PERIOD cycles
    assign wrap = (tick == WRAP_AT);

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            tick <= '0;
        end else if (wrap) begin
            tick <= '0;
        end else begin
            tick <= tick + int_count_t'(1);
        end
    end

    // --------------------------------------------------
    // request hold
    // --------------------------------------------------

    // acceptance wins over a wrap in the same cycle,
    // a wrap during a pending request is simply lost
    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            int_valid <= 1'b0;
        end else if (int_valid && int_ready) begin
            int_valid <= 1'b0;
        end else if (wrap) begin
            int_valid <= 1'b1;
        end
    end

endmodule

// ==== verilog/pcie_tlp_bridge.sv ====
`timescale 1ns/1ps
`include "pcie_bridge_settings.svh"

module pcie_tlp_bridge #(
    parameter int INT_PERIOD = `INT_PERIOD_DEFAULT
) (
    input  logic                       clk_pcie,
    input  logic                       rst,

    // receive, core side
    input  tlp_stream_pkg::core_beat_t rx_data,
    input  logic                       rx_two_dw,
    input  logic                       rx_last,
    input  tlp_stream_pkg::bar_hit_t   rx_bar_hit,
    input  logic                       rx_valid,

    // receive, user side
    output tlp_stream_pkg::tlps_word_t rxs_data,
    output tlp_stream_pkg::keepdw_t    rxs_keepdw,
    output logic                       rxs_first,
    output logic                       rxs_last,
    output tlp_stream_pkg::bar_hit_t   rxs_bar_hit,
    output logic                       rxs_valid,

    // transmit, user side
    input  tlp_stream_pkg::tlps_word_t txs_data,
    input  tlp_stream_pkg::keepdw_t    txs_keepdw,
    input  logic                       txs_last,
    input  logic                       txs_valid,
    output logic                       txs_ready,

    // transmit, core side
    output tlp_stream_pkg::core_beat_t tx_data,
    output tlp_stream_pkg::core_keep_t tx_keep,
    output logic                       tx_last,
    output logic                       tx_valid,
    input  logic                       tx_ready,

    // legacy interrupt
    output logic                       int_valid,
    input  logic                       int_ready
);

    // --------------------------------------------------
    // receive path, 64 to 128
    // --------------------------------------------------

    tlp_rx_packer i_tlp_rx_packer (
        .clk_pcie    (clk_pcie),
        .rst         (rst),
        .rx_data     (rx_data),
        .rx_two_dw   (rx_two_dw),
        .rx_last     (rx_last),
        .rx_bar_hit  (rx_bar_hit),
        .rx_valid    (rx_valid),
        .rxs_data    (rxs_data),
        .rxs_keepdw  (rxs_keepdw),
        .rxs_first   (rxs_first),
        .rxs_last    (rxs_last),
        .rxs_bar_hit (rxs_bar_hit),
        .rxs_valid   (rxs_valid)
    );

    // --------------------------------------------------
    // transmit path, 128 to 64
    // --------------------------------------------------

    tlp_tx_splitter i_tlp_tx_splitter (
        .clk_pcie   (clk_pcie),
        .rst        (rst),
        .txs_data   (txs_data),
        .txs_keepdw (txs_keepdw),
        .txs_last   (txs_last),
        .txs_valid  (txs_valid),
        .txs_ready  (txs_ready),
        .tx_data    (tx_data),
        .tx_keep    (tx_keep),
        .tx_last    (tx_last),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready)
    );

    // --------------------------------------------------
    // periodic legacy interrupt
    // --------------------------------------------------

    legacy_int_requester #(
        .INT_PERIOD (INT_PERIOD)
    ) i_legacy_int_requester (
        .clk_pcie  (clk_pcie),
        .rst       (rst),
        .int_valid (int_valid),
        .int_ready (int_ready)
    );

endmodule

// ==== verification/pcie_tlp_bridge_asserts.sv ====
`timescale 1ns/1ps

module pcie_tlp_bridge_asserts (
    input logic                       clk_pcie,
    input logic                       rst,
    input logic                       tx_valid,
    input tlp_stream_pkg::core_keep_t tx_keep,
    input logic                       int_valid,
    input logic                       int_ready,
    input logic                       rxs_valid,
    input logic                       rxs_last,
    input tlp_stream_pkg::keepdw_t    rxs_keepdw
);

    import tlp_stream_pkg::*;

    // --------------------------------------------------
    // transmit beats carry one or two dwords
    // --------------------------------------------------

    tx_keep_legal: assert property (@(posedge clk_pcie) disable iff (rst)
        tx_valid |-> (tx_keep == core_keep_t'(8'h0f) || tx_keep == core_keep_t'(8'hff)))
        else $error("tx_keep is neither 0x0f nor 0xff");

    // request held until the core takes it
    int_held: assert property (@(posedge clk_pcie) disable iff (rst)
        (int_valid && !int_ready) |=> int_valid)
        else $error("int_valid dropped without int_ready");

    // dword mask fills from bit 0 upward
    // only the final word of a tlp may be short
    rx_keep_contiguous: assert property (@(posedge clk_pcie) disable iff (rst)
        rxs_valid |-> (rxs_keepdw == keepdw_t'(4'hf)
                       || (rxs_last && (rxs_keepdw == keepdw_t'(4'h1)
                                        || rxs_keepdw == keepdw_t'(4'h3)
                                        || rxs_keepdw == keepdw_t'(4'h7)))))
        else $error("rxs_keepdw is not contiguous or a short word does not end its tlp");

endmodule

bind pcie_tlp_bridge pcie_tlp_bridge_asserts i_pcie_tlp_bridge_asserts (
    .clk_pcie   (clk_pcie),
    .rst        (rst),
    .tx_valid   (tx_valid),
    .tx_keep    (tx_keep),
    .int_valid  (int_valid),
    .int_ready  (int_ready),
    .rxs_valid  (rxs_valid),
    .rxs_last   (rxs_last),
    .rxs_keepdw (rxs_keepdw)
);

// ==== verification/pcie_tlp_bridge_tb.sv ====
`timescale 1ns/1ps

module pcie_tlp_bridge_tb;

    import tlp_stream_pkg::*;
    import pcie_cfg_pkg::*;

    localparam int INT_PERIOD = 40;

    logic clk_pcie;
    logic rst;
    core_beat_t rx_data;
    logic rx_two_dw, rx_last, rx_valid;
    bar_hit_t rx_bar_hit;
    tlps_word_t rxs_data;
    keepdw_t rxs_keepdw;
    logic rxs_first, rxs_last, rxs_valid;
    bar_hit_t rxs_bar_hit;
    tlps_word_t txs_data;
    keepdw_t txs_keepdw;
    logic txs_last, txs_valid, txs_ready;
    core_beat_t tx_data;
    core_keep_t tx_keep;
    logic tx_last, tx_valid, tx_ready;
    logic int_valid, int_ready;

    // records loaded from the cases file
    int unsigned rx_ndw[$];
    bar_hit_t rx_bar[$];
    logic [31:0] rx_dw[$];
    keepdw_t exp_rx_keep[$];
    logic exp_rx_first[$];
    logic exp_rx_last[$];
    bar_hit_t exp_rx_bar[$];
    tlps_word_t exp_rx_data[$];
    tlps_word_t tx_word_data[$];
    keepdw_t tx_word_keep[$];
    logic tx_word_last[$];
    int unsigned tx_word_beats[$];
    core_beat_t exp_tx_data[$];
    core_keep_t exp_tx_keep[$];
    logic exp_tx_last[$];

    int unsigned rx_words_seen;
    int unsigned cycle_count;
    int unsigned cycle_limit;

    pcie_tlp_bridge #(
        .INT_PERIOD (INT_PERIOD)
    ) i_pcie_tlp_bridge (.*);

    always #2 clk_pcie = ~clk_pcie;

    // --------------------------------------------------
    // checking helpers
    // --------------------------------------------------

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            $display("error %s expected %h actual %h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    function automatic logic pick_ready();
        return ($urandom % 4) != 0;
    endfunction

    task automatic load_cases();
        int fd;
        reg [8*256-1:0] line;
        string kind;
        logic [31:0] a, b, c, d;
        logic [127:0] w;
        logic [31:0] dw [8];
        fd = $fopen("verification/pcie_tlp_bridge_cases.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open the cases file");
        end
        while (!$feof(fd)) begin
            line = '0;
            void'($fgets(line, fd));
            kind = "";
            void'($sscanf(line, "%s", kind));
            if (kind == "rx") begin
                void'($sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", kind, a, b,
                              dw[0], dw[1], dw[2], dw[3], dw[4], dw[5], dw[6], dw[7]));
                rx_ndw.push_back(a);
                rx_bar.push_back(bar_hit_t'(b));
                for (int i = 0; i < 8; i++) begin
                    rx_dw.push_back(dw[i]);
                end
            end else if (kind == "rxw") begin
                void'($sscanf(line, "%s %h %h %h %h %h", kind, a, b, c, d, w));
                exp_rx_keep.push_back(keepdw_t'(a));
                exp_rx_first.push_back(b[0]);
                exp_rx_last.push_back(c[0]);
                exp_rx_bar.push_back(bar_hit_t'(d));
                exp_rx_data.push_back(w);
            end else if (kind == "tx") begin
                void'($sscanf(line, "%s %h %h %h", kind, a, b, w));
                tx_word_keep.push_back(keepdw_t'(a));
                tx_word_last.push_back(b[0]);
                tx_word_data.push_back(w);
                tx_word_beats.push_back(0);
            end else if (kind == "txb") begin
                void'($sscanf(line, "%s %h %h %h", kind, a, b, w));
                exp_tx_keep.push_back(core_keep_t'(a));
                exp_tx_last.push_back(b[0]);
                exp_tx_data.push_back(core_beat_t'(w));
                tx_word_beats[tx_word_beats.size()-1]++;
            end
        end
        $fclose(fd);
    endtask

    // --------------------------------------------------
    // receive path
    // --------------------------------------------------

    task automatic drive_rx();
        int unsigned ndw;
        for (int r = 0; r < rx_ndw.size(); r++) begin
            ndw = rx_ndw[r];
            for (int i = 0; i < ndw; i += 2) begin
                @(negedge clk_pcie);
                rx_valid   = 1'b1;
                rx_two_dw  = (ndw - i) >= 2;
                rx_last    = (i + 2) >= ndw;
                rx_bar_hit = rx_bar[r];
                rx_data    = {rx_two_dw ? rx_dw[8*r+i+1] : 32'h0, rx_dw[8*r+i]};
            end
        end
        @(negedge clk_pcie);
        rx_valid  = 1'b0;
        rx_last   = 1'b0;
        rx_two_dw = 1'b0;
    endtask

    // masked to the dwords the word claims
    always @(posedge clk_pcie) begin
        if (!rst && rxs_valid) begin
            if (rx_words_seen >= exp_rx_keep.size()) begin
                report_failure("receive word appeared beyond the expected ones");
            end
            check_rx_word(rx_words_seen);
            rx_words_seen++;
        end
    end

    task automatic check_rx_word(input int unsigned n);
        tlps_word_t mask;
        string name;
        for (int i = 0; i < 4; i++) begin
            mask[32*i +: 32] = exp_rx_keep[n][i] ? 32'hffffffff : 32'h0;
        end
        name = $sformatf("rx word %0d", n);
        check_value({name, " keepdw"}, exp_rx_keep[n], rxs_keepdw);
        check_value({name, " first"}, exp_rx_first[n], rxs_first);
        check_value({name, " last"}, exp_rx_last[n], rxs_last);
        check_value({name, " bar hit"}, exp_rx_bar[n], rxs_bar_hit);
        check_value({name, " data"}, exp_rx_data[n] & mask, rxs_data & mask);
    endtask

    // --------------------------------------------------
    // transmit path
    // --------------------------------------------------

    task automatic drive_tx();
        int unsigned beat_idx;
        int unsigned seen;
        logic done;
        core_beat_t mask;
        beat_idx = 0;
        for (int w = 0; w < tx_word_data.size(); w++) begin
            @(negedge clk_pcie);
            txs_data   = tx_word_data[w];
            txs_keepdw = tx_word_keep[w];
            txs_last   = tx_word_last[w];
            txs_valid  = 1'b1;
            tx_ready   = pick_ready();
            seen = 0;
            done = 1'b0;
            while (!done) begin
                @(posedge clk_pcie);
                check_value($sformatf("tx word %0d valid", w), 1, tx_valid);
                if (tx_valid && tx_ready) begin
                    if (seen >= tx_word_beats[w]) begin
                        report_failure("transmit word produced an extra beat");
                    end
                    mask = exp_tx_keep[beat_idx] == core_keep_t'(8'hff) ? '1 : 64'hffffffff;
                    check_value($sformatf("tx beat %0d keep", beat_idx),
                                exp_tx_keep[beat_idx], tx_keep);
                    check_value($sformatf("tx beat %0d last", beat_idx),
                                exp_tx_last[beat_idx], tx_last);
                    check_value($sformatf("tx beat %0d data", beat_idx),
                                exp_tx_data[beat_idx] & mask, tx_data & mask);
                    beat_idx++;
                    seen++;
                end
                if (txs_ready) begin
                    done = 1'b1;
                end else begin
                    @(negedge clk_pcie);
                    tx_ready = pick_ready();
                end
            end
            check_value($sformatf("tx word %0d beat count", w), tx_word_beats[w], seen);
        end
        @(negedge clk_pcie);
        txs_valid = 1'b0;
        tx_ready  = 1'b1;
        @(posedge clk_pcie);
        check_value("tx idle valid", 0, tx_valid);
        check_value("tx idle ready", 1, txs_ready);
        check_value("tx beats consumed", exp_tx_data.size(), beat_idx);
    endtask

    // --------------------------------------------------
    // legacy interrupt
    // --------------------------------------------------

    task automatic check_interrupt();
        for (int k = 1; k < INT_PERIOD; k++) begin
            @(posedge clk_pcie);
            @(negedge clk_pcie);
            check_value("int before first wrap", 0, int_valid);
        end
        @(posedge clk_pcie);
        @(negedge clk_pcie);
        check_value("int at first wrap", 1, int_valid);
        repeat (10) begin
            @(posedge clk_pcie);
            @(negedge clk_pcie);
            check_value("int held without ready", 1, int_valid);
        end
        int_ready = 1'b1;
        @(posedge clk_pcie);
        @(negedge clk_pcie);
        int_ready = 1'b0;
        check_value("int after accept", 0, int_valid);
        for (int k = INT_PERIOD + 12; k < 2 * INT_PERIOD; k++) begin
            @(posedge clk_pcie);
            @(negedge clk_pcie);
            check_value("int before second wrap", 0, int_valid);
        end
        @(posedge clk_pcie);
        @(negedge clk_pcie);
        check_value("int at second wrap", 1, int_valid);
        int_ready = 1'b1;
        @(negedge clk_pcie);
        int_ready = 1'b0;
    endtask

    always @(posedge clk_pcie) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            report_failure($sformatf("timeout after %0d cycles", cycle_count));
        end
    end

    initial begin
        int unsigned total_beats;
        void'($urandom(53));
        clk_pcie = 1'b0;
        rst = 1'b1;
        rx_data = '0;
        rx_two_dw = 1'b0;
        rx_last = 1'b0;
        rx_bar_hit = '0;
        rx_valid = 1'b0;
        txs_data = '0;
        txs_keepdw = '0;
        txs_last = 1'b0;
        txs_valid = 1'b0;
        tx_ready = 1'b1;
        int_ready = 1'b0;
        rx_words_seen = 0;
        cycle_count = 0;
        cycle_limit = 0;
        load_cases();
        total_beats = exp_tx_data.size();
        foreach (rx_ndw[r]) begin
            total_beats += (rx_ndw[r] + 1) / 2;
        end
        cycle_limit = 20 * total_beats + 4 * INT_PERIOD + 100;
        repeat (8) @(posedge clk_pcie);
        @(negedge clk_pcie);
        rst = 1'b0;
        fork
            drive_rx();
            drive_tx();
            check_interrupt();
        join
        repeat (4) @(posedge clk_pcie);
        check_value("rx words received", exp_rx_keep.size(), rx_words_seen);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== verification/pcie_tlp_bridge_cases.txt ====
# rx  ndw bar dw0..dw7 (unused dwords 0) ; rxw keepdw first last bar word128 (dword 0 lowest)
# tx  keepdw last word128 ; txb keep last beat64 (expected beats of the tx record above)
rx  3 01 10000000 10000001 10000002 0 0 0 0 0
rxw 7 1 1 01 00000000100000021000000110000000
rx  4 02 20000000 20000001 20000002 20000003 0 0 0 0
rxw f 1 1 02 20000003200000022000000120000000
rx  5 04 30000000 30000001 30000002 30000003 30000004 0 0 0
rxw f 1 0 04 30000003300000023000000130000000
rxw 1 0 1 04 00000000000000000000000030000004
rx  8 40 40000000 40000001 40000002 40000003 40000004 40000005 40000006 40000007
rxw f 1 0 40 40000003400000024000000140000000
rxw f 0 1 40 40000007400000064000000540000004
rx  2 08 50000000 50000001 0 0 0 0 0 0
rxw 3 1 1 08 00000000000000005000000150000000
rx  1 10 60000000 0 0 0 0 0 0 0
rxw 1 1 1 10 00000000000000000000000060000000
tx  1 0 a3a3a3a3a2a2a2a2a1a1a1a1a0a0a0a0
txb 0f 0 a1a1a1a1a0a0a0a0
tx  3 1 b3b3b3b3b2b2b2b2b1b1b1b1b0b0b0b0
txb ff 1 b1b1b1b1b0b0b0b0
tx  7 0 c3c3c3c3c2c2c2c2c1c1c1c1c0c0c0c0
txb ff 0 c1c1c1c1c0c0c0c0
txb 0f 0 c3c3c3c3c2c2c2c2
tx  f 1 d3d3d3d3d2d2d2d2d1d1d1d1d0d0d0d0
txb ff 0 d1d1d1d1d0d0d0d0
txb ff 1 d3d3d3d3d2d2d2d2
tx  7 1 e3e3e3e3e2e2e2e2e1e1e1e1e0e0e0e0
txb ff 0 e1e1e1e1e0e0e0e0
txb 0f 1 e3e3e3e3e2e2e2e2
tx  f 0 f3f3f3f3f2f2f2f2f1f1f1f1f0f0f0f0
txb ff 0 f1f1f1f1f0f0f0f0
txb ff 0 f3f3f3f3f2f2f2f2

// ==== pcie_tlp_bridge.f ====
+incdir+verilog
verilog/tlp_stream_pkg.sv
verilog/pcie_cfg_pkg.sv
verilog/tlp_rx_packer.sv
verilog/tlp_tx_splitter.sv
verilog/legacy_int_requester.sv
verilog/pcie_tlp_bridge.sv
verification/pcie_tlp_bridge_asserts.sv
verification/pcie_tlp_bridge_tb.sv
